// File: src/icache_pkg.sv
//////////////////////////////
// icache package
// geometry constants and the packed structs shared by the cache blocks
//////////////////////////////
`default_nettype none

package icache_pkg;

  //////////////////////////////
  // geometry
  //////////////////////////////

  // fetch address and instruction words
  localparam int PC_BITS        = 32;
  localparam int INST_BITS      = 32;
  localparam int INST_BYTE_BITS = 2;

  // eight instruction slots per line
  localparam int OFFSET_BITS   = 3;
  localparam int INSTS_IN_LINE = 1 << OFFSET_BITS;
  localparam int LINE_BITS     = INSTS_IN_LINE * INST_BITS;

  // sixteen sets
  localparam int INDEX_BITS = 4;
  localparam int NUM_SETS   = 1 << INDEX_BITS;

  // whatever is left of the pc above index and offset
  localparam int TAG_BITS = PC_BITS - INDEX_BITS - OFFSET_BITS - INST_BYTE_BITS;

  // four ways
  localparam int NUM_WAYS = 4;
  localparam int WAY_BITS = 2;

  // instruction slots handed to fetch per lookup
  localparam int FETCH_WIDTH = 2;

  // block address sent to the next level
  localparam int BLOCK_ADDR_BITS = TAG_BITS + INDEX_BITS;

  //////////////////////////////
  // packed structs
  //////////////////////////////

  // pc split, msb first
  typedef struct packed {
    logic [TAG_BITS-1:0]       tag;
    logic [INDEX_BITS-1:0]     index;
    logic [OFFSET_BITS-1:0]    offset;
    logic [INST_BYTE_BITS-1:0] byte_off;
  } pc_fields_t;

  // block request to memory, victim way travels along
  typedef struct packed {
    logic [BLOCK_ADDR_BITS-1:0] block_addr;
    logic [WAY_BITS-1:0]        way;
  } mem_req_t;

  // memory response with the block it belongs to
  typedef struct packed {
    logic [TAG_BITS-1:0]   tag;
    logic [INDEX_BITS-1:0] index;
    logic [LINE_BITS-1:0]  line;
  } mem_resp_t;

  // array write from the fill register
  typedef struct packed {
    logic [WAY_BITS-1:0]   way;
    logic [INDEX_BITS-1:0] index;
    logic [TAG_BITS-1:0]   tag;
    logic [LINE_BITS-1:0]  line;
  } fill_t;

  // read-out of one way for the addressed set
  typedef struct packed {
    logic                 valid;
    logic [TAG_BITS-1:0]  tag;
    logic [LINE_BITS-1:0] line;
  } way_read_t;

endpackage

`default_nettype wire

// File: src/icache_arrays.sv
//////////////////////////////
// icache arrays
// valid, tag and line storage for all ways, read by set, written by fill
//////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module icache_arrays (
  input  logic                                             clk,
  input  logic                                             reset,
  // read side, set of the current fetch
  input  logic [icache_pkg::INDEX_BITS-1:0]                rd_index_i,
  // fill write from the miss unit
  input  logic                                             fill_valid_i,
  input  icache_pkg::fill_t                                fill_i,
  // flush clears every valid bit
  input  logic                                             flush_i,
  // one read-out per way
  output icache_pkg::way_read_t [icache_pkg::NUM_WAYS-1:0] way_rd_o
);

  //////////////////////////////
  // storage
  //////////////////////////////

  // valid bits, one per way and set
  logic [icache_pkg::NUM_WAYS-1:0][icache_pkg::NUM_SETS-1:0] valid_q;

  // tag memory per way
  logic [icache_pkg::TAG_BITS-1:0]
    tag_mem [icache_pkg::NUM_WAYS][icache_pkg::NUM_SETS];

  // line memory per way
  logic [icache_pkg::LINE_BITS-1:0]
    line_mem [icache_pkg::NUM_WAYS][icache_pkg::NUM_SETS];

  //////////////////////////////
  // valid bits
  //////////////////////////////

  // flush wins over a fill in the same cycle
  // so a line filled while flushing comes back invalid
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      valid_q <= '0;
    end
    else if (flush_i)
    begin
      valid_q <= '0;
    end
    else if (fill_valid_i)
    begin
      // mark the victim way of the filled set
      valid_q[fill_i.way][fill_i.index] <= 1'b1;
    end
  end

  //////////////////////////////
  // tag and line write
  //////////////////////////////

  // tag goes into the victim way chosen at request time
  always_ff @(posedge clk)
  begin
    if (fill_valid_i)
    begin
      tag_mem[fill_i.way][fill_i.index] <= fill_i.tag;
    end
  end

  // whole line written at once, no partial fills
  always_ff @(posedge clk)
  begin
    if (fill_valid_i)
    begin
      line_mem[fill_i.way][fill_i.index] <= fill_i.line;
    end
  end

  //////////////////////////////
  // read by set
  //////////////////////////////

  // asynchronous read of all ways for the fetch set
  // the hit logic sees the result in the same cycle
  always_comb
  begin
    for (int w = 0; w < icache_pkg::NUM_WAYS; w++)
    begin
      way_rd_o[w].valid = valid_q[w][rd_index_i];
      way_rd_o[w].tag   = tag_mem[w][rd_index_i];
      way_rd_o[w].line  = line_mem[w][rd_index_i];
    end
  end

endmodule

`default_nettype wire

// File: src/icache_hit_select.sv
//////////////////////////////
// icache hit select
// tag compare per way, line select and fetch slot extraction
//////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module icache_hit_select (
  input  logic                                                        fetch_req_i,
  input  icache_pkg::pc_fields_t                                      pc_i,
  input  icache_pkg::way_read_t [icache_pkg::NUM_WAYS-1:0]            way_rd_i,
  output logic [icache_pkg::NUM_WAYS-1:0]                             way_hit_o,
  output logic                                                        hit_o,
  output logic [icache_pkg::FETCH_WIDTH-1:0][icache_pkg::INST_BITS-1:0] inst_o,
  output logic [icache_pkg::FETCH_WIDTH-1:0]                          inst_valid_o
);

  // slot number with one spare bit to see the line end
  typedef logic [icache_pkg::OFFSET_BITS:0] slot_t;

  // line of the hitting way, zero when nothing hits
  logic [icache_pkg::LINE_BITS-1:0] hit_line;

  // same line viewed as instruction words
  logic [icache_pkg::INSTS_IN_LINE-1:0][icache_pkg::INST_BITS-1:0] hit_words;

  //////////////////////////////
  // tag compare
  //////////////////////////////

  // a way hits only with a live fetch, a valid line and a matching tag
  always_comb
  begin
    for (int w = 0; w < icache_pkg::NUM_WAYS; w++)
    begin
      way_hit_o[w] = fetch_req_i & way_rd_i[w].valid & (way_rd_i[w].tag == pc_i.tag);
    end
  end

  assign hit_o = |way_hit_o;

  //////////////////////////////
  // line select
  //////////////////////////////

  // and-or mux over the ways
  // fills only go to a missing block so at most one way hits
  always_comb
  begin
    hit_line = '0;
    for (int w = 0; w < icache_pkg::NUM_WAYS; w++)
    begin
      hit_line = hit_line | ({icache_pkg::LINE_BITS{way_hit_o[w]}} & way_rd_i[w].line);
    end
  end

  // word 0 sits in the low bits of the line
  assign hit_words = hit_line;

  //////////////////////////////
  // slot extraction
  //////////////////////////////

  // slot s reads word offset+s of the line
  // past the last word the slot is zero and not valid
  always_comb
  begin
    slot_t slot;
    slot = '0;
    for (int s = 0; s < icache_pkg::FETCH_WIDTH; s++)
    begin
      slot = {1'b0, pc_i.offset} + slot_t'(s);
      if (slot < slot_t'(icache_pkg::INSTS_IN_LINE))
      begin
        inst_o[s]       = hit_words[slot[icache_pkg::OFFSET_BITS-1:0]];
        inst_valid_o[s] = hit_o;
      end
      else
      begin
        inst_o[s]       = '0;
        inst_valid_o[s] = 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/icache_miss_unit.sv
//////////////////////////////
// icache miss unit
// miss pulse, single MSHR, round-robin victim per set and fill register
//////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module icache_miss_unit (
  input  logic                   clk,
  input  logic                   reset,
  // fetch lookup
  input  logic                   fetch_req_i,
  input  icache_pkg::pc_fields_t pc_i,
  input  logic                   hit_i,
  // memory response
  input  logic                   mem_resp_valid_i,
  input  icache_pkg::mem_resp_t  mem_resp_i,
  // memory request
  output logic                   mem_req_valid_o,
  output icache_pkg::mem_req_t   mem_req_o,
  // array write
  output logic                   fill_valid_o,
  output icache_pkg::fill_t      fill_o
);

  // block of the last fetch
  logic [icache_pkg::TAG_BITS-1:0]   miss_tag_q;
  logic [icache_pkg::INDEX_BITS-1:0] miss_index_q;

  // delayed miss flags
  logic miss_d1;
  logic miss_d2;
  logic miss_pulse;

  // single MSHR
  logic                 mshr_valid_q;
  icache_pkg::mem_req_t mshr_q;

  // round-robin victim count per set
  logic [icache_pkg::NUM_SETS-1:0][icache_pkg::WAY_BITS-1:0] rr_q;

  // response and fill
  logic              resp_match;
  logic              fill_valid_q;
  icache_pkg::fill_t fill_q;

  //////////////////////////////
  // miss detection
  //////////////////////////////

  // block address of the fetch, used one cycle later for the request
  always_ff @(posedge clk)
  begin
    if (fetch_req_i)
    begin
      miss_tag_q   <= pc_i.tag;
      miss_index_q <= pc_i.index;
    end
  end

  // a completing fill clears both flags
  // so a miss still pending after it fires again
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      miss_d1 <= 1'b0;
      miss_d2 <= 1'b0;
    end
    else
    begin
      miss_d1 <= fetch_req_i & ~hit_i & ~fill_valid_q;
      miss_d2 <= miss_d1 & ~fill_valid_q;
    end
  end

  // high only in the first cycle of a run of misses
  assign miss_pulse = miss_d1 & ~miss_d2;

  //////////////////////////////
  // request
  //////////////////////////////

  // issue only if the MSHR is free or frees up this cycle
  // a dropped miss is picked up again through fetch replay
  assign mem_req_valid_o = miss_pulse & (~mshr_valid_q | fill_valid_q);

  // victim is the current count of the missing set
  always_comb
  begin
    mem_req_o.block_addr = {miss_tag_q, miss_index_q};
    mem_req_o.way        = rr_q[miss_index_q];
  end

  // count moves on with every issued request, wrapping
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      rr_q <= '0;
    end
    else if (mem_req_valid_o)
    begin
      rr_q[miss_index_q] <= rr_q[miss_index_q] + 1'b1;
    end
  end

  //////////////////////////////
  // MSHR
  //////////////////////////////

  // set on issue, cleared when the fill goes out
  // issue and fill together keep it busy for the new block
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      mshr_valid_q <= 1'b0;
    end
    else if (mem_req_valid_o)
    begin
      mshr_valid_q <= 1'b1;
    end
    else if (fill_valid_q)
    begin
      mshr_valid_q <= 1'b0;
    end
  end

  // outstanding block and its victim way
  always_ff @(posedge clk)
  begin
    if (mem_req_valid_o)
    begin
      mshr_q <= mem_req_o;
    end
  end

  //////////////////////////////
  // response and fill
  //////////////////////////////

  // only the response for the outstanding block is taken
  // anything else on the bus is dropped
  assign resp_match = mem_resp_valid_i & mshr_valid_q & ~fill_valid_q &
                      (mshr_q.block_addr == {mem_resp_i.tag, mem_resp_i.index});

  // fill strobe lasts one cycle
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      fill_valid_q <= 1'b0;
    end
    else
    begin
      fill_valid_q <= resp_match;
    end
  end

  // fill payload, way from the MSHR
  always_ff @(posedge clk)
  begin
    if (resp_match)
    begin
      fill_q.way   <= mshr_q.way;
      fill_q.index <= mem_resp_i.index;
      fill_q.tag   <= mem_resp_i.tag;
      fill_q.line  <= mem_resp_i.line;
    end
  end

  assign fill_valid_o = fill_valid_q;
  assign fill_o       = fill_q;

endmodule

`default_nettype wire

// File: src/icache_top.sv
//////////////////////////////
// icache top
// four-way instruction cache with fetch, memory and flush ports
//////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module icache_top (
  input  logic                                                        clk,
  input  logic                                                        reset,
  // fetch side
  input  logic                                                        fetch_req_i,
  input  icache_pkg::pc_fields_t                                      pc_i,
  output logic [icache_pkg::FETCH_WIDTH-1:0][icache_pkg::INST_BITS-1:0] inst_o,
  output logic [icache_pkg::FETCH_WIDTH-1:0]                          inst_valid_o,
  // memory side
  output logic                                                        mem_req_valid_o,
  output icache_pkg::mem_req_t                                        mem_req_o,
  input  logic                                                        mem_resp_valid_i,
  input  icache_pkg::mem_resp_t                                       mem_resp_i,
  // flush
  input  logic                                                        flush_i,
  output logic                                                        flush_done_o
);

  // set read-out for the fetch index
  icache_pkg::way_read_t [icache_pkg::NUM_WAYS-1:0] way_rd;

  // lookup result
  logic hit;

  // fill write into the arrays
  logic              fill_valid;
  icache_pkg::fill_t fill;

  //////////////////////////////
  // datapath
  //////////////////////////////

  icache_arrays icache_arrays_i (
    .clk          (clk),
    .reset        (reset),
    .rd_index_i   (pc_i.index),
    .fill_valid_i (fill_valid),
    .fill_i       (fill),
    .flush_i      (flush_i),
    .way_rd_o     (way_rd)
  );

  // hit vector stays local, the miss unit works from the flag
  icache_hit_select icache_hit_select_i (
    .fetch_req_i  (fetch_req_i),
    .pc_i         (pc_i),
    .way_rd_i     (way_rd),
    .way_hit_o    (),
    .hit_o        (hit),
    .inst_o       (inst_o),
    .inst_valid_o (inst_valid_o)
  );

  icache_miss_unit icache_miss_unit_i (
    .clk              (clk),
    .reset            (reset),
    .fetch_req_i      (fetch_req_i),
    .pc_i             (pc_i),
    .hit_i            (hit),
    .mem_resp_valid_i (mem_resp_valid_i),
    .mem_resp_i       (mem_resp_i),
    .mem_req_valid_o  (mem_req_valid_o),
    .mem_req_o        (mem_req_o),
    .fill_valid_o     (fill_valid),
    .fill_o           (fill)
  );

  //////////////////////////////
  // flush done
  //////////////////////////////

  // valid bits clear at the flush edge, done follows one cycle later
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      flush_done_o <= 1'b0;
    end
    else
    begin
      flush_done_o <= flush_i;
    end
  end

endmodule

`default_nettype wire

// File: verif/icache_tb.sv
//////////////////////////////
// icache testbench
// file driven fetch, response and flush sequence checked against a block data rule
//////////////////////////////
`default_nettype none
`timescale 1ns/1ps

module icache_tb;

  // one stimulus line with op, pc, hit, req and way fields
  typedef struct packed {
    logic [3:0]  op;
    logic [31:0] pc;
    logic [3:0]  exp_hit;
    logic [3:0]  exp_req;
    logic [3:0]  exp_way;
  } stim_t;

  logic                   clk;
  logic                   reset;
  logic                   fetch_req;
  icache_pkg::pc_fields_t pc;
  logic [icache_pkg::FETCH_WIDTH-1:0][icache_pkg::INST_BITS-1:0] inst;
  logic [icache_pkg::FETCH_WIDTH-1:0] inst_valid;
  logic                   mem_req_valid;
  icache_pkg::mem_req_t   mem_req;
  logic                   mem_resp_valid;
  icache_pkg::mem_resp_t  mem_resp;
  logic                   flush;
  logic                   flush_done;

  logic [47:0] stim_mem [0:63];
  int          mismatch_count;
  int          other_count;

  icache_top icache_top_i (
    .clk              (clk),
    .reset            (reset),
    .fetch_req_i      (fetch_req),
    .pc_i             (pc),
    .inst_o           (inst),
    .inst_valid_o     (inst_valid),
    .mem_req_valid_o  (mem_req_valid),
    .mem_req_o        (mem_req),
    .mem_resp_valid_i (mem_resp_valid),
    .mem_resp_i       (mem_resp),
    .flush_i          (flush),
    .flush_done_o     (flush_done)
  );

  // 10 ns clock
  initial
  begin
    clk = 1'b0;
    forever
    begin
      #5 clk = ~clk;
    end
  end

  //////////////////////////////
  // memory data rule
  //////////////////////////////

  // word k of block b is b shifted left by three plus k
  function automatic logic [31:0] word_of_block(
    input logic [icache_pkg::BLOCK_ADDR_BITS-1:0] block, input int k);
    return (32'(block) << 3) + 32'(k);
  endfunction

  // whole line of a block with word 0 in the low bits
  function automatic logic [icache_pkg::LINE_BITS-1:0] line_of_block(
    input logic [icache_pkg::BLOCK_ADDR_BITS-1:0] block);
    logic [icache_pkg::LINE_BITS-1:0] line;
    line = '0;
    for (int k = 0; k < icache_pkg::INSTS_IN_LINE; k++)
    begin
      line[k*icache_pkg::INST_BITS +: icache_pkg::INST_BITS] = word_of_block(block, k);
    end
    return line;
  endfunction

  //////////////////////////////
  // checks
  //////////////////////////////

  task automatic check_hex(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
    assert (actual === expected)
    else
    begin
      mismatch_count++;
      $display("mismatch %s expected %h actual %h at %0t", name, expected, actual, $time);
    end
  endtask

  task automatic report_error(input string what);
    other_count++;
    $display("error: %s at %0t", what, $time);
  endtask

  //////////////////////////////
  // operations
  //////////////////////////////

  // fetch and hold the pc, then release it
  task automatic fetch_and_check(input stim_t st);
    icache_pkg::pc_fields_t                fpc;
    logic [icache_pkg::BLOCK_ADDR_BITS-1:0] block;
    logic [31:0]                            exp0;
    logic [31:0]                            exp1;
    logic                                   exp_v1;
    bit                                     seen;
    fpc   = icache_pkg::pc_fields_t'(st.pc);
    // block address is pc bits 31 to 5
    block = st.pc[31:5];
    seen  = 1'b0;
    @(posedge clk);
    #1;
    fetch_req = 1'b1;
    pc        = fpc;
    if (st.exp_hit[0])
    begin
      // replay until slot 0 comes back
      // a fresh fill needs two cycles before it hits
      for (int c = 0; c < 50 && !seen; c++)
      begin
        @(negedge clk);
        seen = inst_valid[0];
      end
      assert (seen) else report_error("fetch never hit within 50 cycles");
      if (seen)
      begin
        // slot 1 runs off the line end at offset 7
        exp_v1 = (int'(fpc.offset) + 1 < icache_pkg::INSTS_IN_LINE);
        exp0   = word_of_block(block, int'(fpc.offset));
        exp1   = exp_v1 ? word_of_block(block, int'(fpc.offset) + 1) : 32'h0;
        check_hex("inst_o[0]", 64'(exp0), 64'(inst[0]));
        check_hex("inst_o[1]", 64'(exp1), 64'(inst[1]));
        check_hex("inst_valid_o[1]", 64'(exp_v1), 64'(inst_valid[1]));
      end
    end
    else
    begin
      @(negedge clk);
      check_hex("inst_valid_o", 64'(0), 64'(inst_valid));
      if (st.exp_req[0])
      begin
        for (int c = 0; c < 50 && !seen; c++)
        begin
          @(negedge clk);
          seen = mem_req_valid;
        end
        assert (seen) else report_error("no memory request within 50 cycles");
        check_hex("mem_req_o.block_addr", 64'(block), 64'(mem_req.block_addr));
        check_hex("mem_req_o.way", 64'(st.exp_way), 64'(mem_req.way));
      end
      // holding the miss gives no further request
      for (int c = 0; c < 5; c++)
      begin
        @(negedge clk);
        check_hex("mem_req_valid_o", 64'(0), 64'(mem_req_valid));
        check_hex("inst_valid_o[0]", 64'(0), 64'(inst_valid[0]));
      end
    end
    @(posedge clk);
    #1;
    fetch_req = 1'b0;
  endtask

  // one cycle response
  // a wrong tag names a block nobody asked for
  task automatic send_response(input logic [31:0] raw_pc, input bit wrong_tag);
    icache_pkg::pc_fields_t rpc;
    rpc = icache_pkg::pc_fields_t'(raw_pc);
    if (wrong_tag)
    begin
      rpc.tag[0] = ~rpc.tag[0];
    end
    @(posedge clk);
    #1;
    mem_resp_valid  = 1'b1;
    mem_resp.tag    = rpc.tag;
    mem_resp.index  = rpc.index;
    mem_resp.line   = line_of_block({rpc.tag, rpc.index});
    @(posedge clk);
    #1;
    mem_resp_valid = 1'b0;
  endtask

  // done is high in the cycle after the flush and only then
  task automatic flush_and_check();
    @(posedge clk);
    #1;
    flush = 1'b1;
    @(negedge clk);
    check_hex("flush_done_o", 64'(0), 64'(flush_done));
    @(posedge clk);
    #1;
    flush = 1'b0;
    @(negedge clk);
    check_hex("flush_done_o", 64'(1), 64'(flush_done));
    @(negedge clk);
    check_hex("flush_done_o", 64'(0), 64'(flush_done));
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial
  begin
    stim_t st;
    mismatch_count = 0;
    other_count    = 0;
    reset          = 1'b1;
    fetch_req      = 1'b0;
    pc             = '0;
    mem_resp_valid = 1'b0;
    mem_resp       = '0;
    flush          = 1'b0;
    // op 0 marks the end of the list
    for (int i = 0; i < 64; i++)
    begin
      stim_mem[i] = '0;
    end
    $readmemh("verif/icache_stimulus.txt", stim_mem);
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    assert (stim_mem[0][47:44] != 4'h0)
    else report_error("stimulus file empty or missing");
    for (int i = 0; i < 64; i++)
    begin
      st = stim_t'(stim_mem[i]);
      if (st.op == 4'h0)
      begin
        break;
      end
      case (st.op)
        4'h1: fetch_and_check(st);
        4'h2: send_response(st.pc, 1'b0);
        4'h3: send_response(st.pc, 1'b1);
        4'h4: flush_and_check();
        default: report_error("unknown operation in stimulus file");
      endcase
    end
    $display("errors: %0d mismatches, %0d other", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0)
    begin
      $display("Testbench passed");
    end
    else
    begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/icache_stimulus.txt
// op_pc_hit_req_way in hex, op 1 fetch, 2 respond, 3 respond with wrong tag, 4 flush
// hit, req and way are the expected fetch result, request pulse and victim way
1_0000024C_0_1_0
2_0000024C_0_0_0
1_0000024C_1_0_0
1_0000025C_1_0_0
1_00000440_0_1_1
2_00000440_0_0_0
1_00000440_1_0_0
1_00000654_0_1_2
2_00000654_0_0_0
1_00000654_1_0_0
1_00000858_0_1_3
2_00000858_0_0_0
1_00000858_1_0_0
1_00000A44_0_1_0
2_00000A44_0_0_0
1_00000A44_1_0_0
// fifth fill took way 0, first tag is gone
1_0000024C_0_1_1
1_00000440_1_0_0
1_00000654_1_0_0
1_00000858_1_0_0
3_0000024C_0_0_0
1_0000024C_0_0_0
2_0000024C_0_0_0
1_0000024C_1_0_0
4_00000000_0_0_0
1_00000654_0_1_2
1_00000A44_0_0_0
1_0000024C_0_0_0
1_00000858_0_0_0

// File: verilog.f
src/icache_pkg.sv
src/icache_arrays.sv
src/icache_hit_select.sv
src/icache_miss_unit.sv
src/icache_top.sv
verif/icache_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = icache_tb
FILELIST = verilog.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
